//--- rtl/ldpcCodePkg.sv
`default_nettype none

package ldpcCodePkg;

    // code 3 is not defined and decodes as rate 1/2.
    typedef enum logic [1:0] {
        rate1_2 = 2'd0,
        rate2_3 = 2'd1,
        rate4_5 = 2'd2
    } codeRate_t;

    // codeword length in 64-bit words.
    function automatic logic [7:0] wordsPerFrame(codeRate_t rate, logic codeLength4096);
        logic [7:0] shortWords;
        case (rate)
            rate2_3: shortWords = 8'd24;
            rate4_5: shortWords = 8'd20;
            default: shortWords = 8'd32;
        endcase
        return codeLength4096 ? {shortWords[5:0], 2'b00} : shortWords;
    endfunction

    // the long code carries a four word marker.
    function automatic logic [2:0] markerWords(logic codeLength4096);
        return codeLength4096 ? 3'd4 : 3'd1;
    endfunction

endpackage

`default_nettype wire

//--- rtl/framerPkg.sv
`default_nettype none

package framerPkg;

    typedef enum logic [1:0] {
        outOfSync   = 2'b00,
        skipPayload = 2'b01,
        testSync    = 2'b11
    } syncState_t;

    localparam int bitsPerWord = 64;

    localparam logic [bitsPerWord-1:0] syncWord = 64'hFCB8_8938_D8D7_6A4F;

    // holds the four word sum and the threshold.
    localparam int corrWidth = 11;

endpackage

`default_nettype wire

//--- rtl/symbolDerotator.sv
`timescale 1ns/1ps
`default_nettype none

module symbolDerotator (
    input  wire         clk,
    input  wire         reset,
    input  wire  [1:0]  symbol,
    input  wire         symbolEn,
    input  wire  [1:0]  rotation,
    output logic        dataBit,
    output logic        bitEn
);

    logic [1:0] rotated;
    logic       qBit;
    logic       qPending;

    // symbol[1] is the I sign, symbol[0] the Q sign.
    always_comb begin
        case (rotation)
            2'd0:    rotated = symbol;
            2'd1:    rotated = {symbol[0], ~symbol[1]};
            2'd2:    rotated = ~symbol;
            default: rotated = {~symbol[0], symbol[1]};
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bitEn <= 1'b0;
            qPending <= 1'b0;
        end else begin
            bitEn <= symbolEn | qPending;
            qPending <= symbolEn;
        end
    end

    // I goes out first, Q follows one cycle later.
    always_ff @(posedge clk) begin
        if (symbolEn) begin
            dataBit <= rotated[1];
            qBit <= rotated[0];
        end else if (qPending) begin
            dataBit <= qBit;
        end
    end

endmodule

`default_nettype wire

//--- rtl/syncCorrelator.sv
`timescale 1ns/1ps
`default_nettype none

module syncCorrelator (
    input  wire                                   clk,
    input  wire                                   reset,
    input  wire                                   dataBit,
    input  wire                                   bitEn,
    input  wire                                   codeLength4096,
    input  wire signed [framerPkg::corrWidth-1:0] syncThreshold,
    output logic                                  syncDetected,
    output logic                                  negPolarity
);

    localparam int histDepth = 3 * framerPkg::bitsPerWord;

    logic        [framerPkg::bitsPerWord-1:0] corrSR;
    logic        [framerPkg::bitsPerWord-1:0] nextSR;
    logic signed [7:0]                        bitSum;
    logic signed [7:0]                        sumHist [0:histDepth-1];
    logic signed [framerPkg::corrWidth-1:0]   longSum;
    logic signed [framerPkg::corrWidth-1:0]   negThreshold;

    // score of one nibble from the number of agreeing bits.
    function automatic logic signed [3:0] nibbleScore(logic [3:0] data, logic [3:0] pattern);
        logic [3:0] agree;
        logic signed [3:0] score;
        agree = ~(data ^ pattern);
        case (agree)
            4'b1111:                            score = 4'sd4;
            4'b1110, 4'b1101, 4'b1011, 4'b0111: score = 4'sd2;
            4'b1000, 4'b0100, 4'b0010, 4'b0001: score = -4'sd2;
            4'b0000:                            score = -4'sd4;
            default:                            score = 4'sd0;
        endcase
        return score;
    endfunction

    // correlate against the register as it will be after this bit.
    assign nextSR = {corrSR[framerPkg::bitsPerWord-2:0], dataBit};

    always_comb begin
        bitSum = '0;
        for (int n = 0; n < framerPkg::bitsPerWord / 4; n++) begin
            bitSum = bitSum + nibbleScore(nextSR[4*n +: 4], framerPkg::syncWord[4*n +: 4]);
        end
    end

    always_ff @(posedge clk) begin
        if (bitEn) begin
            corrSR <= nextSR;
            sumHist[0] <= codeLength4096 ? bitSum : 8'sd0;
            for (int n = 1; n < histDepth; n++) begin
                sumHist[n] <= sumHist[n-1];
            end
        end
    end

    // long marker is sync, inverted sync, sync, sync.
    assign longSum = bitSum
                   + sumHist[framerPkg::bitsPerWord-1]
                   - sumHist[2*framerPkg::bitsPerWord-1]
                   + sumHist[3*framerPkg::bitsPerWord-1];

    assign negThreshold = -syncThreshold;

    always_ff @(posedge clk) begin
        if (reset) begin
            syncDetected <= 1'b0;
            negPolarity <= 1'b0;
        end else if (bitEn) begin
            if (longSum > syncThreshold) begin
                syncDetected <= 1'b1;
                negPolarity <= 1'b0;
            end else if (longSum < negThreshold) begin
                syncDetected <= 1'b1;
                negPolarity <= 1'b1;
            end else begin
                syncDetected <= 1'b0;
                negPolarity <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/ldpcFramer.sv
`timescale 1ns/1ps
`default_nettype none

module ldpcFramer #(
    parameter int maxSyncCount = 5
) (
    input  wire                                   clk,
    input  wire                                   reset,
    input  wire                                   dataBit,
    input  wire                                   bitEn,
    input  wire                                   codeLength4096,
    input  wire ldpcCodePkg::codeRate_t           codeRate,
    input  wire signed [framerPkg::corrWidth-1:0] syncThreshold,
    output logic [1:0]                            rotation,
    output framerPkg::syncState_t                 frameSyncState,
    output logic                                  frameSync,
    output logic                                  codewordEn
);

    localparam int countWidth = $clog2(maxSyncCount + 1);
    localparam logic [countWidth-1:0] countMax = countWidth'(maxSyncCount);
    localparam logic [5:0] lastBit = 6'(framerPkg::bitsPerWord - 1);

    logic [7:0]             payloadWords;
    logic [7:0]             frameWords;
    logic [7:0]             skipWords;
    framerPkg::syncState_t  syncState;
    logic [5:0]             bitCount;
    logic [7:0]             wordCount;
    logic [countWidth-1:0]  syncCount;
    logic                   endOfCount;
    logic                   syncDetected;
    logic                   negPolarity;
    logic                   posHit;

    syncCorrelator correlator (
        .clk            (clk),
        .reset          (reset),
        .dataBit        (dataBit),
        .bitEn          (bitEn),
        .codeLength4096 (codeLength4096),
        .syncThreshold  (syncThreshold),
        .syncDetected   (syncDetected),
        .negPolarity    (negPolarity)
    );

    assign payloadWords = ldpcCodePkg::wordsPerFrame(codeRate, codeLength4096);
    assign frameWords = payloadWords + {5'd0, ldpcCodePkg::markerWords(codeLength4096)};
    // payload plus the leading marker words, the last marker word is the test window.
    assign skipWords = frameWords - 8'd1;

    assign endOfCount = (bitCount == 6'd0) && (wordCount == 8'd0);
    assign posHit = syncDetected && !negPolarity;
    assign frameSyncState = syncState;

    always_ff @(posedge clk) begin
        if (reset) begin
            syncState <= framerPkg::outOfSync;
            frameSync <= 1'b0;
            codewordEn <= 1'b0;
            rotation <= 2'd0;
            syncCount <= '0;
            bitCount <= lastBit;
            wordCount <= frameWords - 8'd1;
        end else if (bitEn) begin
            case (syncState)
                framerPkg::outOfSync: begin
                    frameSync <= 1'b0;
                    if (syncDetected) begin
                        // inverted marker means a half turn off.
                        rotation <= {rotation[1] ^ negPolarity, rotation[0]};
                        syncCount <= countWidth'(1);
                        bitCount <= lastBit;
                        wordCount <= skipWords - 8'd1;
                        syncState <= framerPkg::skipPayload;
                    end else if (endOfCount) begin
                        // a whole frame without a marker, try the next phase.
                        rotation <= rotation + 2'd1;
                        bitCount <= lastBit;
                        wordCount <= frameWords - 8'd1;
                    end else if (bitCount == 6'd0) begin
                        bitCount <= lastBit;
                        wordCount <= wordCount - 8'd1;
                    end else begin
                        bitCount <= bitCount - 6'd1;
                    end
                end
                framerPkg::skipPayload: begin
                    if (endOfCount) begin
                        bitCount <= lastBit;
                        syncState <= framerPkg::testSync;
                    end else if (bitCount == 6'd0) begin
                        bitCount <= lastBit;
                        wordCount <= wordCount - 8'd1;
                    end else begin
                        bitCount <= bitCount - 6'd1;
                    end
                end
                framerPkg::testSync: begin
                    if (bitCount == 6'd0) begin
                        if (posHit) begin
                            if (syncCount != countMax) begin
                                syncCount <= syncCount + 1'b1;
                            end
                            if (syncCount >= countMax - 1'b1) begin
                                frameSync <= 1'b1;
                                codewordEn <= 1'b1;
                            end else begin
                                codewordEn <= frameSync;
                            end
                            bitCount <= lastBit;
                            wordCount <= skipWords - 8'd1;
                            syncState <= framerPkg::skipPayload;
                        end else if (syncCount == '0) begin
                            rotation <= rotation + 2'd1;
                            codewordEn <= 1'b0;
                            bitCount <= lastBit;
                            wordCount <= frameWords - 8'd1;
                            syncState <= framerPkg::outOfSync;
                        end else begin
                            syncCount <= syncCount - 1'b1;
                            codewordEn <= frameSync;
                            bitCount <= lastBit;
                            wordCount <= skipWords - 8'd1;
                            syncState <= framerPkg::skipPayload;
                        end
                    end else begin
                        bitCount <= bitCount - 6'd1;
                    end
                end
                default: begin
                    syncState <= framerPkg::outOfSync;
                    frameSync <= 1'b0;
                    codewordEn <= 1'b0;
                    syncCount <= '0;
                    bitCount <= lastBit;
                    wordCount <= frameWords - 8'd1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/codewordPacker.sv
`timescale 1ns/1ps
`default_nettype none

module codewordPacker (
    input  wire                                  clk,
    input  wire                                  reset,
    input  wire                                  dataBit,
    input  wire                                  bitEn,
    input  wire                                  codewordEn,
    input  wire                                  codeLength4096,
    input  wire ldpcCodePkg::codeRate_t          codeRate,
    output logic [framerPkg::bitsPerWord-1:0]    word,
    output logic                                 wordValid,
    output logic                                 firstWord
);

    localparam logic [5:0] lastBit = 6'(framerPkg::bitsPerWord - 1);

    logic [7:0] payloadWords;
    logic [7:0] frameWords;
    logic       bitDelay;
    logic       active;
    logic [7:0] wordIdx;
    logic [5:0] bitIdx;
    logic [7:0] curWord;
    logic [5:0] curBit;
    logic       inPayload;

    assign payloadWords = ldpcCodePkg::wordsPerFrame(codeRate, codeLength4096);
    assign frameWords = payloadWords + {5'd0, ldpcCodePkg::markerWords(codeLength4096)};

    // codewordEn rises one bit into the payload, so bits run one behind.
    assign curWord = active ? wordIdx : 8'd0;
    assign curBit = active ? bitIdx : 6'd0;
    assign inPayload = curWord < payloadWords;

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            wordValid <= 1'b0;
            firstWord <= 1'b0;
            wordIdx <= 8'd0;
            bitIdx <= 6'd0;
        end else begin
            wordValid <= 1'b0;
            if (bitEn) begin
                if (!codewordEn) begin
                    active <= 1'b0;
                end else begin
                    active <= 1'b1;
                    bitIdx <= curBit + 6'd1;
                    if (curBit == lastBit) begin
                        wordIdx <= (curWord == frameWords - 8'd1) ? 8'd0 : curWord + 8'd1;
                    end else begin
                        wordIdx <= curWord;
                    end
                    if (inPayload && curBit == lastBit) begin
                        wordValid <= 1'b1;
                        firstWord <= (curWord == 8'd0);
                    end
                end
            end
        end
    end

    // oldest bit ends up in the MSB.
    always_ff @(posedge clk) begin
        if (bitEn) begin
            bitDelay <= dataBit;
            if (codewordEn && inPayload) begin
                word <= {word[framerPkg::bitsPerWord-2:0], bitDelay};
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/ldpcSyncTop.sv
`timescale 1ns/1ps
`default_nettype none

module ldpcSyncTop #(
    parameter int maxSyncCount = 5
) (
    input  wire                                   clk,
    input  wire                                   reset,
    input  wire  [1:0]                            symbol,
    input  wire                                   symbolEn,
    input  wire                                   codeLength4096,
    input  wire ldpcCodePkg::codeRate_t           codeRate,
    input  wire signed [framerPkg::corrWidth-1:0] syncThreshold,
    output logic [1:0]                            rotation,
    output framerPkg::syncState_t                 frameSyncState,
    output logic                                  frameSync,
    output logic                                  codewordEn,
    output logic [framerPkg::bitsPerWord-1:0]     word,
    output logic                                  wordValid,
    output logic                                  firstWord
);

    logic dataBit;
    logic bitEn;

    symbolDerotator derotator (
        .clk      (clk),
        .reset    (reset),
        .symbol   (symbol),
        .symbolEn (symbolEn),
        .rotation (rotation),
        .dataBit  (dataBit),
        .bitEn    (bitEn)
    );

    ldpcFramer #(
        .maxSyncCount (maxSyncCount)
    ) framer (
        .clk            (clk),
        .reset          (reset),
        .dataBit        (dataBit),
        .bitEn          (bitEn),
        .codeLength4096 (codeLength4096),
        .codeRate       (codeRate),
        .syncThreshold  (syncThreshold),
        .rotation       (rotation),
        .frameSyncState (frameSyncState),
        .frameSync      (frameSync),
        .codewordEn     (codewordEn)
    );

    codewordPacker packer (
        .clk            (clk),
        .reset          (reset),
        .dataBit        (dataBit),
        .bitEn          (bitEn),
        .codewordEn     (codewordEn),
        .codeLength4096 (codeLength4096),
        .codeRate       (codeRate),
        .word           (word),
        .wordValid      (wordValid),
        .firstWord      (firstWord)
    );

endmodule

`default_nettype wire

//--- dv/frameGen.svh
`ifndef FRAME_GEN_SVH
`define FRAME_GEN_SVH

// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1.
function automatic logic [31:0] lfsrNext(logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
endfunction

// one step per bit taken.
function automatic logic [63:0] randomWord();
    logic [63:0] value;
    value = '0;
    for (int n = 0; n < 64; n++) begin
        lfsrState = lfsrNext(lfsrState);
        value = {value[62:0], lfsrState[0]};
    end
    return value;
endfunction

// each step maps (I, Q) to (not Q, I), the inverse of derotator rotation 1.
function automatic logic [1:0] channelRotate(logic [1:0] sym, int steps);
    logic [1:0] turned;
    turned = sym;
    for (int n = 0; n < steps; n++) begin
        turned = {~turned[0], turned[1]};
    end
    return turned;
endfunction

task automatic sendSymbol(logic [1:0] sym);
    @(posedge clk);
    #1;
    symbol = sym;
    symbolEn = 1'b1;
    @(posedge clk);
    #1;
    symbolEn = 1'b0;
endtask

// oldest bit first, I before Q.
task automatic sendWord(logic [63:0] value);
    for (int n = 63; n > 0; n -= 2) begin
        sendSymbol(channelRotate(value[n -: 2], channelRot));
    end
endtask

task automatic sendFrame(int markerErrors, logic randomMarker);
    logic [63:0] marker;
    logic [63:0] payload [$];
    int          markerCount;
    markerCount = codeLength4096 ? 4 : 1;
    for (int m = 0; m < markerCount; m++) begin
        // long marker inverts its second word.
        marker = (m == 1) ? ~markerWord : markerWord;
        if (randomMarker) begin
            marker = randomWord();
        end
        for (int e = 0; e < markerErrors; e++) begin
            marker[7 * e] = ~marker[7 * e];
        end
        sendWord(marker);
    end
    for (int n = 0; n < payloadWordsFor(codeRate, codeLength4096); n++) begin
        payload.push_back(randomWord());
    end
    sentWords = payload;
    foreach (payload[n]) begin
        sendWord(payload[n]);
    end
endtask

`endif

//--- dv/ldpcSyncTb.sv
`timescale 1ns/1ps
`default_nettype none

module ldpcSyncTb;

    localparam int maxSyncCount = 2;
    localparam int timeoutFrames = 40;
    localparam logic [63:0] markerWord = 64'hFCB8_8938_D8D7_6A4F;

    logic                   clk;
    logic                   reset;
    logic [1:0]             symbol;
    logic                   symbolEn;
    logic                   codeLength4096;
    ldpcCodePkg::codeRate_t codeRate;
    logic signed [10:0]     syncThreshold;
    logic [1:0]             rotation;
    framerPkg::syncState_t  frameSyncState;
    logic                   frameSync;
    logic                   codewordEn;
    logic [63:0]            word;
    logic                   wordValid;
    logic                   firstWord;

    logic [31:0] lfsrState;
    int          channelRot;
    logic [63:0] sentWords [$];
    logic        idleCheck;
    int          errors;
    int          checks;
    int          testCount;
    int          testStartErrors;
    int          framesSeen;
    int          wordsInFrame;
    int          lastFrameWords;

    `include "frameGen.svh"

    ldpcSyncTop #(
        .maxSyncCount (maxSyncCount)
    ) DUT (
        .clk            (clk),
        .reset          (reset),
        .symbol         (symbol),
        .symbolEn       (symbolEn),
        .codeLength4096 (codeLength4096),
        .codeRate       (codeRate),
        .syncThreshold  (syncThreshold),
        .rotation       (rotation),
        .frameSyncState (frameSyncState),
        .frameSync      (frameSync),
        .codewordEn     (codewordEn),
        .word           (word),
        .wordValid      (wordValid),
        .firstWord      (firstWord)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // codeword words per rate, short code and long code.
    function automatic int payloadWordsFor(ldpcCodePkg::codeRate_t rate, logic long4096);
        case (rate)
            ldpcCodePkg::rate2_3: return long4096 ? 96 : 24;
            ldpcCodePkg::rate4_5: return long4096 ? 80 : 20;
            default:              return long4096 ? 128 : 32;
        endcase
    endfunction

    task automatic expectEqual(string name, logic [63:0] actual, logic [63:0] expected);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic expectTrue(logic condition, string what);
        checks++;
        assert (condition) else begin
            errors++;
            $display("ERROR: %s", what);
        end
    endtask

    task automatic startTest(logic long4096, ldpcCodePkg::codeRate_t rate, int threshold,
                             int channel);
        @(posedge clk);
        #1;
        reset = 1'b1;
        codeLength4096 = long4096;
        codeRate = rate;
        syncThreshold = 11'(threshold);
        channelRot = channel;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        testStartErrors = errors;
    endtask

    task automatic finishTest(string name);
        testCount++;
        $display("test %0d, %s: %0d errors", testCount, name, errors - testStartErrors);
    endtask

    task automatic acquireLock();
        for (int n = 0; n < timeoutFrames && !frameSync; n++) begin
            sendFrame(0, 1'b0);
        end
        expectTrue(frameSync, "timed out waiting for frame lock");
    endtask

    task automatic waitCodewords(int count);
        int target;
        target = framesSeen + count;
        for (int n = 0; n < timeoutFrames && framesSeen < target; n++) begin
            sendFrame(0, 1'b0);
        end
        expectTrue(framesSeen >= target, "timed out waiting for codewords");
    endtask

    task automatic checkFrameLength(logic long4096, ldpcCodePkg::codeRate_t rate, int threshold);
        startTest(long4096, rate, threshold, 0);
        acquireLock();
        waitCodewords(2);
        expectEqual("wordValid count", lastFrameWords, payloadWordsFor(rate, long4096));
        finishTest($sformatf("frame length, rate %0d, long code %0d", rate, long4096));
    endtask

    // each packed word is the next payload word sent.
    always @(posedge clk) begin
        if (!reset && wordValid) begin
            if (firstWord) begin
                lastFrameWords = wordsInFrame;
                wordsInFrame = 0;
                framesSeen++;
            end
            wordsInFrame++;
            if (sentWords.size() == 0) begin
                expectTrue(1'b0, "wordValid with no payload word pending");
            end else begin
                expectEqual("word", word, sentWords.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        if (idleCheck) begin
            expectEqual("frameSync", frameSync, 64'd0);
            expectEqual("codewordEn", codewordEn, 64'd0);
            expectEqual("wordValid", wordValid, 64'd0);
            expectEqual("frameSyncState", frameSyncState, framerPkg::outOfSync);
            expectEqual("rotation", rotation, 64'd0);
        end
    end

    // codeword enable never runs ahead of lock.
    assert property (@(posedge clk) disable iff (reset) codewordEn |-> frameSync)
        else begin
            errors++;
            $display("FAILED codewordEn: %h while frameSync is %h", codewordEn, frameSync);
        end

    initial begin
        reset = 1'b1;
        symbol = 2'b00;
        symbolEn = 1'b0;
        codeLength4096 = 1'b0;
        codeRate = ldpcCodePkg::rate1_2;
        syncThreshold = 11'sd50;
        lfsrState = 32'hd116_7b1e;
        channelRot = 0;
        idleCheck = 1'b0;
        errors = 0;
        checks = 0;
        testCount = 0;
        testStartErrors = 0;
        framesSeen = 0;
        wordsInFrame = 0;
        lastFrameWords = 0;

        startTest(1'b0, ldpcCodePkg::rate1_2, 50, 0);
        idleCheck = 1'b1;
        // shorter than one frame, so the phase search has not stepped yet.
        repeat (16) begin
            sendWord(randomWord());
        end
        idleCheck = 1'b0;
        finishTest("reset state under noise");

        for (int c = 0; c < 4; c++) begin
            startTest(1'b0, ldpcCodePkg::rate1_2, 50, c);
            acquireLock();
            // derotator rotation c undoes c inverse steps of the channel.
            expectEqual("rotation", rotation, c);
            waitCodewords(2);
            finishTest($sformatf("acquisition, channel rotation %0d", c));
        end

        checkFrameLength(1'b0, ldpcCodePkg::rate2_3, 50);
        checkFrameLength(1'b0, ldpcCodePkg::rate4_5, 50);
        // a partial long marker scores near 64, so the threshold sits above that.
        checkFrameLength(1'b1, ldpcCodePkg::rate1_2, 150);

        // score 52 is a hit, score 48 a miss.
        startTest(1'b0, ldpcCodePkg::rate1_2, 50, 0);
        acquireLock();
        repeat (3) begin
            sendFrame(6, 1'b0);
        end
        expectEqual("frameSync", frameSync, 64'd1);
        for (int n = 1; n <= maxSyncCount + 1; n++) begin
            sendFrame(8, 1'b0);
            expectEqual("frameSync", frameSync, n <= maxSyncCount);
        end
        finishTest("marker bit errors");

        startTest(1'b0, ldpcCodePkg::rate1_2, 50, 1);
        acquireLock();
        for (int n = 1; n <= maxSyncCount + 1; n++) begin
            sendFrame(0, 1'b1);
            expectEqual("frameSync", frameSync, n <= maxSyncCount);
        end
        expectEqual("codewordEn", codewordEn, 64'd0);
        acquireLock();
        finishTest("loss of lock and recovery");

        $display("%0d tests, %0d checks, %0d errors", testCount, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+dv
rtl/ldpcCodePkg.sv
rtl/framerPkg.sv
rtl/symbolDerotator.sv
rtl/syncCorrelator.sv
rtl/ldpcFramer.sv
rtl/codewordPacker.sv
rtl/ldpcSyncTop.sv
dv/ldpcSyncTb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and scans the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module ldpcSyncTb \
    -o ldpcSyncSim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/ldpcSyncSim > sim.log 2>&1 ; cat sim.log

grep -q "Finished with errors" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
